// File: ingress_agg.f
hdl/ingress_pkg.sv
hdl/ingress_port_buffer.sv
hdl/ingress_arbiter.sv
hdl/ingress_frame_counters.sv
hdl/ingress_top.sv
bench/ingress_asserts.sv
bench/ingress_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and pass only if the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ingress_tb \
    -f ingress_agg.f -o ingress_sim &&
sim_out="$(./obj_dir/ingress_sim)" ; printf '%s\n' "$sim_out" ;
printf '%s\n' "$sim_out" | grep -q -F '*** PASSED ***' &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

// File: bench/ingress_tb.sv
// Directed tests against a per-port scoreboard; expected packets are queued when sent
// Soak traffic waits for a port's previous packet to leave, so every soak packet fits

`timescale 1ns/1ns

module ingress_tb
    import ingress_pkg::*;
;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          SOAK_PKTS      = 60;
    localparam logic [31:0] SEED           = 32'h45d6;

    logic                  core_clk_ifc;
    logic                  rst_n;
    logic [NUM_PORTS-1:0]  port_valid;
    logic [DATA_W-1:0]     port_data [NUM_PORTS];
    logic [DATA_BYTES-1:0] port_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0]  port_last;
    logic [NUM_PORTS-1:0]  port_enable;
    logic [NUM_PORTS-1:0]  cnt_clear;
    logic                  out_valid;
    logic [DATA_W-1:0]     out_data;
    logic [DATA_BYTES-1:0] out_keep;
    logic                  out_last;
    logic [PORT_IDX_W-1:0] out_user;
    logic                  out_ready;
    logic [CNT_W-1:0]      frame_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0]  buf_overflow;

    // Scoreboard words are {last, keep, data}
    logic [DATA_W+DATA_BYTES:0] exp_q [NUM_PORTS][$];
    logic [CNT_W-1:0]           exp_cnt [NUM_PORTS];
    int                         ovf_cnt [NUM_PORTS];
    int                         order_q [$];
    int                         errors;
    string                      test_name;
    logic                       ready_rand;
    logic                       mid_pkt;
    logic [PORT_IDX_W-1:0]      cur_user;

    ingress_top dut0 (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////
    // Output monitor
    always @(posedge core_clk_ifc) begin
        logic [DATA_W+DATA_BYTES:0] expected;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_overflow[p]) ovf_cnt[p]++;
            end
            if (out_valid && out_ready) begin
                if (mid_pkt && out_user != cur_user) begin
                    $display("%s: port %0d word cut into a packet from port %0d",
                             test_name, out_user, cur_user);
                    errors++;
                end
                if (exp_q[out_user].size() == 0) begin
                    $display("%s: unexpected word %h from port %0d", test_name, out_data, out_user);
                    errors++;
                end else begin
                    expected = exp_q[out_user].pop_front();
                    if (expected !== {out_last, out_keep, out_data}) begin
                        $display("mismatch %s: port %0d last/keep/data expected %h actual %h",
                                 test_name, out_user, expected, {out_last, out_keep, out_data});
                        errors++;
                    end
                end
                mid_pkt  = !out_last;
                cur_user = out_user;
                if (out_last) order_q.push_back(int'(out_user));
            end
        end
    end

    ////////////////////////////////////////
    // Helpers
    function automatic logic [NUM_PORTS-1:0] one_hot(input int p);
        logic [NUM_PORTS-1:0] m;
        m    = '0;
        m[p] = 1'b1;
        return m;
    endfunction

    function automatic logic pkt_fits(input int used_words, input int len);
        return len <= BUF_DEPTH - used_words;
    endfunction

    function automatic int pending(input logic [NUM_PORTS-1:0] mask);
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic tick();
        @(negedge core_clk_ifc);
        if (ready_rand) out_ready = 1'($urandom_range(0, 1));
    endtask

    task automatic check_int(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_counts();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_int($sformatf("frame_cnt[%0d]", p), int'(exp_cnt[p]), int'(frame_cnt[p]));
        end
    endtask

    // Same length on every port in mask, in lockstep; kept marks packets that must come out
    task automatic send_pkts(input logic [NUM_PORTS-1:0] mask, input int len,
                             input logic [NUM_PORTS-1:0] kept);
        logic [DATA_BYTES-1:0] keep;
        logic [DATA_BYTES-1:0] tail_keep;
        tail_keep = DATA_BYTES'((1 << $urandom_range(1, DATA_BYTES)) - 1);
        for (int w = 0; w < len; w++) begin
            tick();
            keep = (w == len - 1) ? tail_keep : '1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (mask[p]) begin
                    port_valid[p] = 1'b1;
                    port_data[p]  = $urandom;
                    port_keep[p]  = keep;
                    port_last[p]  = (w == len - 1);
                    if (kept[p]) exp_q[p].push_back({port_last[p], keep, port_data[p]});
                end
            end
        end
        tick();
        port_valid = '0;
        port_last  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p] && kept[p]) exp_cnt[p] = exp_cnt[p] + 1'b1;
        end
    endtask

    // All ports also waits for the output to go idle
    task automatic wait_drain(input logic [NUM_PORTS-1:0] mask);
        int cycles;
        cycles = 0;
        while ((pending(mask) != 0 || (mask == '1 && out_valid)) && cycles < TIMEOUT_CYCLES) begin
            tick();
            cycles++;
        end
        if (pending(mask) != 0 || (mask == '1 && out_valid)) begin
            $display("%s: timed out with %0d expected words still inside the DUT",
                     test_name, pending(mask));
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Tests
    task automatic test_simultaneous();
        test_name = "simultaneous";
        order_q.delete();
        send_pkts('1, 6, '1);
        wait_drain('1);
        check_int("packets out", NUM_PORTS, order_q.size());
        for (int i = 0; i < order_q.size(); i++) begin
            check_int($sformatf("port of packet %0d", i), i, order_q[i]);
        end
        check_counts();
    endtask

    task automatic test_single_port();
        int lens [3];
        test_name = "single port";
        lens = '{1, 5, 16};
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < 3; i++) begin
                send_pkts(one_hot(p), lens[i], one_hot(p));
                wait_drain('1);
                check_counts();
            end
        end
    endtask

    task automatic test_disabled();
        test_name = "disabled port";
        port_enable[2] = 1'b0;
        for (int n = 0; n < 3; n++) begin
            send_pkts('1, 3 + n, ~one_hot(2));
            wait_drain('1);
        end
        check_counts();
        port_enable[2] = 1'b1;
    endtask

    task automatic test_overflow();
        int ovf_start;
        test_name = "overflow";
        ovf_start = ovf_cnt[1];
        out_ready = 1'b0;
        send_pkts(one_hot(1), 12, {NUM_PORTS{pkt_fits(0, 12)}} & one_hot(1));
        send_pkts(one_hot(1), 8, {NUM_PORTS{pkt_fits(12, 8)}} & one_hot(1));
        check_int("overflow pulses", 1, ovf_cnt[1] - ovf_start);
        check_counts();
        out_ready = 1'b1;
        wait_drain('1);
        // Longer than the whole buffer
        send_pkts(one_hot(1), 20, {NUM_PORTS{pkt_fits(0, 20)}} & one_hot(1));
        wait_drain('1);
        check_int("overflow pulses", 2, ovf_cnt[1] - ovf_start);
        check_counts();
    endtask

    task automatic test_clear();
        test_name = "counter clear";
        send_pkts('1, 2, '1);
        wait_drain('1);
        check_counts();
        cnt_clear[3] = 1'b1;
        tick();
        cnt_clear[3] = 1'b0;
        exp_cnt[3]   = '0;
        check_counts();
    endtask

    task automatic test_soak();
        int p;
        int len;
        test_name  = "soak";
        ready_rand = 1'b1;
        for (int n = 0; n < SOAK_PKTS; n++) begin
            p   = $urandom_range(0, NUM_PORTS - 1);
            len = $urandom_range(1, 8);
            wait_drain(one_hot(p));
            send_pkts(one_hot(p), len, one_hot(p));
        end
        wait_drain('1);
        ready_rand = 1'b0;
        out_ready  = 1'b1;
        check_counts();
    endtask

    initial begin
        void'($urandom(SEED));
        errors      = 0;
        ready_rand  = 1'b0;
        mid_pkt     = 1'b0;
        cur_user    = '0;
        test_name   = "reset";
        rst_n       = 1'b0;
        out_ready   = 1'b1;
        port_valid  = '0;
        port_last   = '0;
        port_enable = '1;
        cnt_clear   = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_data[p] = '0;
            port_keep[p] = '0;
            exp_cnt[p]   = '0;
        end
        repeat (3) @(negedge core_clk_ifc);
        rst_n = 1'b1;

        // Runs first so the priority pointer is still at port 0
        test_simultaneous();
        test_single_port();
        test_disabled();
        test_overflow();
        test_clear();
        test_soak();

        $display("ingress_tb done, errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/ingress_asserts.sv
// Output stream checks only; ingress ports and buffer contents are checked by the scoreboard

`timescale 1ns/1ns

module ingress_asserts
    import ingress_pkg::*;
(
    input logic                  core_clk_ifc,
    input logic                  rst_n,
    input logic [NUM_PORTS-1:0]  pkt_avail,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  out_last,
    input logic [DATA_W-1:0]     out_data,
    input logic [DATA_BYTES-1:0] out_keep,
    input logic [PORT_IDX_W-1:0] out_user
);

    // A stalled word stays put until it transfers
    hold_while_stalled: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_user))
        else $error("output word changed while out_ready was low");

    // The granted buffer keeps committed words until its last word leaves
    user_in_range: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_valid |-> int'(out_user) < NUM_PORTS && pkt_avail[out_user])
        else $error("out_user names a port with no committed packet");

    idle_in_reset: assert property (@(posedge core_clk_ifc) !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind ingress_top ingress_asserts u_asserts (
    .core_clk_ifc (core_clk_ifc),
    .rst_n        (rst_n),
    .pkt_avail    (pkt_avail),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_last     (out_last),
    .out_data     (out_data),
    .out_keep     (out_keep),
    .out_user     (out_user)
);

// File: hdl/ingress_top.sv
// Single clock domain; ingress ports have no ready and drop what does not fit
// out_user carries the source port of each output packet

`timescale 1ns/1ns

module ingress_top
    import ingress_pkg::*;
(
    input  logic                  core_clk_ifc,
    input  logic                  rst_n,
    input  logic [NUM_PORTS-1:0]  port_valid,
    input  logic [DATA_W-1:0]     port_data [NUM_PORTS],
    input  logic [DATA_BYTES-1:0] port_keep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]  port_last,
    input  logic [NUM_PORTS-1:0]  port_enable,
    input  logic [NUM_PORTS-1:0]  cnt_clear,
    output logic                  out_valid,
    output logic [DATA_W-1:0]     out_data,
    output logic [DATA_BYTES-1:0] out_keep,
    output logic                  out_last,
    output logic [PORT_IDX_W-1:0] out_user,
    input  logic                  out_ready,
    output logic [CNT_W-1:0]      frame_cnt [NUM_PORTS],
    output logic [NUM_PORTS-1:0]  buf_overflow
);

    logic [NUM_PORTS-1:0]  pkt_avail;
    logic [NUM_PORTS-1:0]  rd_en;
    logic [NUM_PORTS-1:0]  rd_last;
    logic [DATA_W-1:0]     rd_data [NUM_PORTS];
    logic [DATA_BYTES-1:0] rd_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0]  frame_done;

    ////////////////////////////////////////
    // Per-port packet buffers
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        ingress_port_buffer u_buf (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .enable       (port_enable[p]),
            .in_valid     (port_valid[p]),
            .in_last      (port_last[p]),
            .in_data      (port_data[p]),
            .in_keep      (port_keep[p]),
            .rd_en        (rd_en[p]),
            .pkt_avail    (pkt_avail[p]),
            .rd_last      (rd_last[p]),
            .rd_data      (rd_data[p]),
            .rd_keep      (rd_keep[p]),
            .frame_done   (frame_done[p]),
            .overflow     (buf_overflow[p])
        );
    end

    ingress_arbiter u_arb (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .pkt_avail    (pkt_avail),
        .rd_data      (rd_data),
        .rd_keep      (rd_keep),
        .rd_last      (rd_last),
        .rd_en        (rd_en),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_user     (out_user),
        .out_ready    (out_ready)
    );

    ingress_frame_counters u_cnt (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .frame_done   (frame_done),
        .cnt_clear    (cnt_clear),
        .frame_cnt    (frame_cnt)
    );

endmodule

// File: hdl/ingress_frame_counters.sv
// Counters wrap at 2**CNT_W
// Clear wins over a frame in the same cycle

`timescale 1ns/1ns

module ingress_frame_counters
    import ingress_pkg::*;
(
    input  logic                 core_clk_ifc,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] frame_done,
    input  logic [NUM_PORTS-1:0] cnt_clear,
    output logic [CNT_W-1:0]     frame_cnt [NUM_PORTS]
);

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                frame_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin
                    frame_cnt[p] <= '0;
                end else if (frame_done[p]) begin
                    frame_cnt[p] <= frame_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/ingress_arbiter.sv
// Round-robin over whole packets; a granted packet is sent to its last word before the next grant
// The search wraps by index overflow, so NUM_PORTS must be a power of two

`timescale 1ns/1ns

module ingress_arbiter
    import ingress_pkg::*;
(
    input  logic                  core_clk_ifc,
    input  logic                  rst_n,
    input  logic [NUM_PORTS-1:0]  pkt_avail,
    input  logic [DATA_W-1:0]     rd_data [NUM_PORTS],
    input  logic [DATA_BYTES-1:0] rd_keep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]  rd_last,
    output logic [NUM_PORTS-1:0]  rd_en,
    output logic                  out_valid,
    output logic                  out_last,
    output logic [DATA_W-1:0]     out_data,
    output logic [DATA_BYTES-1:0] out_keep,
    output logic [PORT_IDX_W-1:0] out_user,
    input  logic                  out_ready
);

    arb_state_t            state;
    logic [PORT_IDX_W-1:0] grant;
    logic [PORT_IDX_W-1:0] prio_ptr;
    logic [PORT_IDX_W-1:0] pick;
    logic                  pick_valid;
    logic                  xfer;

    ////////////////////////////////////////
    // First requesting port from the priority pointer
    always_comb begin
        logic [PORT_IDX_W-1:0] idx;
        pick       = prio_ptr;
        pick_valid = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = prio_ptr + PORT_IDX_W'(i);
            if (!pick_valid && pkt_avail[idx]) begin
                pick       = idx;
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            grant    <= '0;
            prio_ptr <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant    <= pick;
                        prio_ptr <= pick + 1'b1;
                        state    <= ARB_SEND;
                    end
                end
                ARB_SEND: begin
                    if (xfer && rd_last[grant]) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Output mux; the buffer word holds until its pop
    assign out_valid = (state == ARB_SEND);
    assign out_data  = rd_data[grant];
    assign out_keep  = rd_keep[grant];
    assign out_last  = rd_last[grant];
    assign out_user  = grant;
    assign xfer      = out_valid && out_ready;

    always_comb begin
        rd_en        = '0;
        rd_en[grant] = xfer;
    end

endmodule

// File: hdl/ingress_port_buffer.sv
// Store-and-forward buffer; only whole committed packets are visible on the read side
// Ingress has no ready, so a packet that does not fit in free space is dropped whole

`timescale 1ns/1ns

module ingress_port_buffer
    import ingress_pkg::*;
(
    input  logic                  core_clk_ifc,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  logic [DATA_W-1:0]     in_data,
    input  logic [DATA_BYTES-1:0] in_keep,
    input  logic                  rd_en,
    output logic                  pkt_avail,
    output logic                  rd_last,
    output logic [DATA_W-1:0]     rd_data,
    output logic [DATA_BYTES-1:0] rd_keep,
    output logic                  frame_done,
    output logic                  overflow
);

    logic [DATA_W-1:0]     mem_data [BUF_DEPTH];
    logic [DATA_BYTES-1:0] mem_keep [BUF_DEPTH];
    logic                  mem_last [BUF_DEPTH];

    // One extra pointer bit tells a full buffer from an empty one
    logic [BUF_ADDR_W:0]   wr_ptr;
    logic [BUF_ADDR_W:0]   commit_ptr;
    logic [BUF_ADDR_W:0]   rd_ptr;
    logic [BUF_ADDR_W:0]   used;

    wr_state_t             state;
    logic                  sop;
    logic                  full;
    logic                  wr_en;

    // Committed plus tentative words
    assign used  = wr_ptr - rd_ptr;
    assign full  = (used == (BUF_ADDR_W+1)'(BUF_DEPTH));
    assign wr_en = in_valid && (state == WR_ACCEPT) && !(sop && !enable) && !full;

    ////////////////////////////////////////
    // Storage
    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            mem_data[wr_ptr[BUF_ADDR_W-1:0]] <= in_data;
            mem_keep[wr_ptr[BUF_ADDR_W-1:0]] <= in_keep;
            mem_last[wr_ptr[BUF_ADDR_W-1:0]] <= in_last;
        end
    end

    ////////////////////////////////////////
    // Write side and read pointer
    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state      <= WR_ACCEPT;
            sop        <= 1'b1;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            frame_done <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            overflow   <= 1'b0;

            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (in_valid) begin
                sop <= in_last;
                if (state == WR_DROP) begin
                    // Discard the rest of a dropped packet
                    if (in_last) begin
                        state <= WR_ACCEPT;
                    end
                end else if (sop && !enable) begin
                    // Enable is sampled on the first word only
                    if (!in_last) begin
                        state <= WR_DROP;
                    end
                end else if (full) begin
                    // Rewind the partial packet
                    wr_ptr   <= commit_ptr;
                    overflow <= 1'b1;
                    if (!in_last) begin
                        state <= WR_DROP;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (in_last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                        frame_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Show-ahead read of committed words
    assign pkt_avail = (commit_ptr != rd_ptr);
    assign rd_data   = mem_data[rd_ptr[BUF_ADDR_W-1:0]];
    assign rd_keep   = mem_keep[rd_ptr[BUF_ADDR_W-1:0]];
    assign rd_last   = mem_last[rd_ptr[BUF_ADDR_W-1:0]];

endmodule

// File: hdl/ingress_pkg.sv
// Sizes are fixed here; NUM_PORTS must equal 2**PORT_IDX_W for the arbiter's wrap-around search
// BUF_DEPTH must equal 2**BUF_ADDR_W

package ingress_pkg;

    ////////////////////////////////////////
    // Port and bus sizes
    localparam int NUM_PORTS  = 4;
    localparam int PORT_IDX_W = 2;
    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = 32;

    // Per-port packet buffer
    localparam int BUF_DEPTH  = 16;
    localparam int BUF_ADDR_W = 4;

    localparam int CNT_W      = 16;

    ////////////////////////////////////////
    // State encodings
    typedef enum logic {
        WR_ACCEPT = 1'b0,
        WR_DROP   = 1'b1
    } wr_state_t;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_SEND = 1'b1
    } arb_state_t;

endpackage
